//--- common/host_regs_pkg.sv
package host_regs_pkg;

	// ------------------------------
	// register offsets in the window
	// ------------------------------
	typedef enum logic [7:0] {
		CTRL      = 8'h00, // max packet length
		EN        = 8'h01, // router and counter enables
		IEN       = 8'h02, // interrupt enables
		INT       = 8'h03, // interrupt status, w1c
		PAR_CNT   = 8'h04, // parity error count, ro
		LEN_CNT   = 8'h05, // oversized packet count, ro
		ILL_CNT   = 8'h06, // illegal address count, ro
		ADDR0_CNT = 8'h09, // packets to dest 0, ro
		ADDR1_CNT = 8'h0A, // packets to dest 1, ro
		ADDR2_CNT = 8'h0B, // packets to dest 2, ro
		CLR       = 8'h0C  // self clearing commands
	} reg_off_e;

	// ------------------------------
	// enable register fields
	// ------------------------------
	localparam int EN_ROUTER_BIT = 0; // whole router
	localparam int EN_PAR_BIT    = 1;
	localparam int EN_LEN_BIT    = 2;
	// bit 3 reserved, reads 0
	localparam int EN_ADDR0_BIT  = 4;
	localparam int EN_ADDR1_BIT  = 5;
	localparam int EN_ADDR2_BIT  = 6;
	localparam int EN_ILL_BIT    = 7;

	// interrupt enable and status share positions
	localparam int INT_PAR_BIT = 0;
	localparam int INT_LEN_BIT = 1;
	localparam int INT_ILL_BIT = 2;

	// clear register command bits
	localparam int CLR_SOFT_BIT      = 0; // all regs back to reset
	localparam int CLR_ERR_CNTS_BIT  = 1; // par, len, ill counters
	localparam int CLR_ADDR_CNTS_BIT = 2; // dest 0..2 counters
	localparam int CLR_INT_BIT       = 3; // ien and status

	localparam logic [7:0] RST_EN_REG = 8'h01; // only the router on

	localparam logic [1:0] DEST_ILLEGAL = 2'd3; // no port behind dest 3

endpackage

//--- common/host_bus_pkg.sv
package host_bus_pkg;

	// ------------------------------
	// host bus direction
	// ------------------------------
	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} host_op_e;

	// four phase handshake sequencing
	typedef enum logic [1:0] {
		IDLE     = 2'd0, // waiting for req, ack low
		ACK      = 2'd1, // first cycle with ack high
		WAIT_REL = 2'd2  // host still holds req
	} bus_state_e;

endpackage

//--- design/host_access_ctl.sv
`timescale 1ns/100ps

module host_access_ctl #(
	parameter logic [15:0] BASE_ADDR = 16'h1000,
	parameter int          CNT_WIDTH = 8
) (
	input  logic                    clock,
	input  logic                    rst_addr_cnts_fld,
	input  logic                    req,
	input  host_bus_pkg::host_op_e  wr_rd,
	input  logic [15:0]             addr,
	input  logic [7:0]              ctl_rdata,
	input  logic                    ctl_hit,
	input  logic [CNT_WIDTH-1:0]    par_cnt,
	input  logic [CNT_WIDTH-1:0]    len_cnt,
	input  logic [CNT_WIDTH-1:0]    ill_cnt,
	input  logic [CNT_WIDTH-1:0]    addr0_cnt,
	input  logic [CNT_WIDTH-1:0]    addr1_cnt,
	input  logic [CNT_WIDTH-1:0]    addr2_cnt,
	output logic                    ack,
	output logic [7:0]              rdata,
	output logic                    reg_wr,
	output host_regs_pkg::reg_off_e reg_off
);

	// last address of the window, one bit wider so the top can't wrap
	localparam logic [16:0] WIN_END = {1'b0, BASE_ADDR} + 17'h000FF;

	host_bus_pkg::bus_state_e state;
	logic        in_window;
	logic [15:0] addr_rel;  // address relative to the base
	logic        accept;    // req seen in IDLE, this edge completes the access
	logic [7:0]  rd_mux;

	// ------------------------------
	// window decode
	// ------------------------------
	assign in_window = (addr >= BASE_ADDR) && ({1'b0, addr} <= WIN_END);
	assign addr_rel  = addr - BASE_ADDR;
	assign reg_off   = host_regs_pkg::reg_off_e'(addr_rel[7:0]);

	assign accept = (state == host_bus_pkg::IDLE) && req;
	assign reg_wr = accept && in_window && (wr_rd == host_bus_pkg::OP_WRITE); // lands this edge

	// read data combine, zero for writes and misses
	always_comb begin
		rd_mux = 8'h00;
		if (in_window && (wr_rd == host_bus_pkg::OP_READ)) begin
			if (ctl_hit) begin
				rd_mux = ctl_rdata;
			end else begin
				case (reg_off)
					host_regs_pkg::PAR_CNT:   rd_mux = 8'(par_cnt); // zero extend
					host_regs_pkg::LEN_CNT:   rd_mux = 8'(len_cnt);
					host_regs_pkg::ILL_CNT:   rd_mux = 8'(ill_cnt);
					host_regs_pkg::ADDR0_CNT: rd_mux = 8'(addr0_cnt);
					host_regs_pkg::ADDR1_CNT: rd_mux = 8'(addr1_cnt);
					host_regs_pkg::ADDR2_CNT: rd_mux = 8'(addr2_cnt);
					default:                  rd_mux = 8'h00; // unmapped
				endcase
			end
		end
	end

	// ------------------------------
	// handshake fsm
	// ------------------------------
	always_ff @(posedge clock) begin
		if (rst_addr_cnts_fld) begin
			state <= host_bus_pkg::IDLE;
			ack   <= 1'b0;
			rdata <= 8'h00;
		end else begin
			case (state)
				host_bus_pkg::IDLE: begin
					if (accept) begin
						state <= host_bus_pkg::ACK;
						ack   <= 1'b1;
						rdata <= rd_mux; // valid together with ack
					end
				end
				host_bus_pkg::ACK: begin
					if (req) begin
						state <= host_bus_pkg::WAIT_REL; // host holding, rdata frozen
					end else begin
						state <= host_bus_pkg::IDLE;
						ack   <= 1'b0;
						rdata <= 8'h00;
					end
				end
				host_bus_pkg::WAIT_REL: begin
					if (!req) begin
						state <= host_bus_pkg::IDLE;
						ack   <= 1'b0;
						rdata <= 8'h00;
					end
				end
				default: begin
					state <= host_bus_pkg::IDLE;
					ack   <= 1'b0;
				end
			endcase
		end
	end

	// ack only ever answers a request seen on the previous edge
	a_ack_needs_req: assert property (@(posedge clock) disable iff (rst_addr_cnts_fld)
		$rose(ack) |-> $past(req));

	// held req must not produce a second write
	a_wr_one_cycle: assert property (@(posedge clock) disable iff (rst_addr_cnts_fld)
		reg_wr |=> !reg_wr);

endmodule

//--- ctl_regs/ctl_regs.sv
`timescale 1ns/100ps

module ctl_regs #(
	parameter logic [5:0] RST_MAX_PKT = 6'h3F
) (
	input  logic                    clock,
	input  logic                    rst_addr_cnts_fld,
	input  logic                    reg_wr,
	input  host_regs_pkg::reg_off_e reg_off,
	input  logic [7:0]              wdata,
	input  logic                    parity_err,
	input  logic                    len_err,
	input  logic                    pkt_done,
	input  logic [1:0]              pkt_dest,
	output logic [7:0]              ctl_rdata,
	output logic                    ctl_hit,
	output logic [7:0]              en_reg,
	output logic [5:0]              max_pkt_len,
	output logic                    router_en,
	output logic                    irq,
	output logic                    clr_err_cnts,
	output logic                    clr_addr_cnts
);

	localparam int         EN_RSVD_BIT  = 3;
	localparam logic [7:0] EN_RSVD_MASK = 8'h01 << EN_RSVD_BIT;

	logic [2:0] ien_reg;
	logic [2:0] int_reg;   // sticky status
	logic [3:0] clr_reg;   // lives one cycle after the write
	logic [2:0] int_set;
	logic [2:0] int_w1c;
	logic       clr_soft_bit;
	logic       clr_err_cnts_bit;
	logic       clr_addr_cnts_bit;
	logic       clr_int_bit;

	assign clr_soft_bit      = clr_reg[host_regs_pkg::CLR_SOFT_BIT];
	assign clr_err_cnts_bit  = clr_reg[host_regs_pkg::CLR_ERR_CNTS_BIT];
	assign clr_addr_cnts_bit = clr_reg[host_regs_pkg::CLR_ADDR_CNTS_BIT];
	assign clr_int_bit       = clr_reg[host_regs_pkg::CLR_INT_BIT];

	// soft clear takes the counters back to zero as well
	assign clr_err_cnts  = clr_err_cnts_bit | clr_soft_bit;
	assign clr_addr_cnts = clr_addr_cnts_bit | clr_soft_bit;

	assign router_en = en_reg[host_regs_pkg::EN_ROUTER_BIT];

	// ------------------------------
	// interrupt sources
	// ------------------------------
	always_comb begin
		int_set = 3'b000;
		int_set[host_regs_pkg::INT_PAR_BIT] = parity_err & ien_reg[host_regs_pkg::INT_PAR_BIT];
		int_set[host_regs_pkg::INT_LEN_BIT] = len_err & ien_reg[host_regs_pkg::INT_LEN_BIT];
		int_set[host_regs_pkg::INT_ILL_BIT] = pkt_done && (pkt_dest == host_regs_pkg::DEST_ILLEGAL)
			&& ien_reg[host_regs_pkg::INT_ILL_BIT];
	end

	// write 1 to clear mask, only on a status write
	assign int_w1c = (reg_wr && (reg_off == host_regs_pkg::INT)) ? wdata[2:0] : 3'b000;

	// ------------------------------
	// register file
	// ------------------------------
	always_ff @(posedge clock) begin
		if (rst_addr_cnts_fld || clr_soft_bit) begin
			max_pkt_len <= RST_MAX_PKT;
			en_reg      <= host_regs_pkg::RST_EN_REG;
			ien_reg     <= 3'b000;
			int_reg     <= 3'b000;
			clr_reg     <= 4'h0;
		end else begin
			clr_reg <= 4'h0; // default, command bits self clear
			if (clr_int_bit) begin
				ien_reg <= 3'b000;
				int_reg <= 3'b000;
			end else begin
				int_reg <= (int_reg & ~int_w1c) | int_set; // set beats clear
			end
			if (reg_wr) begin
				case (reg_off)
					host_regs_pkg::CTRL: max_pkt_len <= wdata[5:0];
					host_regs_pkg::EN:   en_reg      <= wdata & ~EN_RSVD_MASK; // bit 3 stays 0
					host_regs_pkg::IEN: begin
						if (!clr_int_bit) begin
							ien_reg <= wdata[2:0];
						end
					end
					host_regs_pkg::CLR:  clr_reg     <= wdata[3:0];
					default: ; // status handled above, counters ro
				endcase
			end
		end
	end

	// irq one cycle behind the status bits
	always_ff @(posedge clock) begin
		if (rst_addr_cnts_fld) begin
			irq <= 1'b0;
		end else begin
			irq <= |int_reg;
		end
	end

	// ------------------------------
	// read side, decoded here only
	// ------------------------------
	always_comb begin
		ctl_hit   = 1'b1;
		ctl_rdata = 8'h00;
		case (reg_off)
			host_regs_pkg::CTRL: ctl_rdata = {2'b00, max_pkt_len};
			host_regs_pkg::EN:   ctl_rdata = en_reg;
			host_regs_pkg::IEN:  ctl_rdata = {5'b00000, ien_reg};
			host_regs_pkg::INT:  ctl_rdata = {5'b00000, int_reg};
			host_regs_pkg::CLR:  ctl_rdata = {4'h0, clr_reg};
			default:             ctl_hit   = 1'b0; // counters or unmapped
		endcase
	end

	// reserved enable bit can't be set by any write, reset or soft clear
	a_en_rsvd_zero: assert property (@(posedge clock) disable iff (rst_addr_cnts_fld)
		!en_reg[EN_RSVD_BIT]);

endmodule

//--- design/event_counters.sv
`timescale 1ns/100ps

module event_counters #(
	parameter int CNT_WIDTH = 8
) (
	input  logic                 clock,
	input  logic                 rst_addr_cnts_fld,
	input  logic [7:0]           en_reg,
	input  logic                 clr_err_cnts,
	input  logic                 clr_addr_cnts,
	input  logic                 parity_err,
	input  logic                 len_err,
	input  logic                 pkt_done,
	input  logic [1:0]           pkt_dest,
	output logic [CNT_WIDTH-1:0] par_cnt,
	output logic [CNT_WIDTH-1:0] len_cnt,
	output logic [CNT_WIDTH-1:0] ill_cnt,
	output logic [CNT_WIDTH-1:0] addr0_cnt,
	output logic [CNT_WIDTH-1:0] addr1_cnt,
	output logic [CNT_WIDTH-1:0] addr2_cnt
);

	// slot order, error group first then address group
	localparam int N_CNT = 6;

	logic [N_CNT-1:0]     inc;        // gated event per counter
	logic [N_CNT-1:0]     clr;
	logic [CNT_WIDTH-1:0] cnt [N_CNT];
	logic                 gate;       // router enable

	assign gate = en_reg[host_regs_pkg::EN_ROUTER_BIT];

	// ------------------------------
	// event sort and gating
	// ------------------------------
	assign inc[0] = gate & parity_err & en_reg[host_regs_pkg::EN_PAR_BIT];
	assign inc[1] = gate & len_err & en_reg[host_regs_pkg::EN_LEN_BIT];
	assign inc[2] = gate & pkt_done & (pkt_dest == host_regs_pkg::DEST_ILLEGAL)
		& en_reg[host_regs_pkg::EN_ILL_BIT];
	assign inc[3] = gate & pkt_done & (pkt_dest == 2'd0) & en_reg[host_regs_pkg::EN_ADDR0_BIT];
	assign inc[4] = gate & pkt_done & (pkt_dest == 2'd1) & en_reg[host_regs_pkg::EN_ADDR1_BIT];
	assign inc[5] = gate & pkt_done & (pkt_dest == 2'd2) & en_reg[host_regs_pkg::EN_ADDR2_BIT];

	assign clr = {{3{clr_addr_cnts}}, {3{clr_err_cnts}}};

	// ------------------------------
	// saturating counters
	// ------------------------------
	for (genvar i = 0; i < N_CNT; i++) begin : g_cnt
		always_ff @(posedge clock) begin
			if (rst_addr_cnts_fld || clr[i]) begin // clear beats increment
				cnt[i] <= '0;
			end else if (inc[i] && (cnt[i] != '1)) begin
				cnt[i] <= cnt[i] + 1'b1;
			end
		end

		// stuck at max until its group clear
		a_no_wrap: assert property (@(posedge clock) disable iff (rst_addr_cnts_fld)
			((cnt[i] == '1) && !clr[i]) |=> (cnt[i] != '0));
	end

	assign par_cnt   = cnt[0];
	assign len_cnt   = cnt[1];
	assign ill_cnt   = cnt[2];
	assign addr0_cnt = cnt[3];
	assign addr1_cnt = cnt[4];
	assign addr2_cnt = cnt[5];

endmodule

//--- design/host_ctl_top.sv
`timescale 1ns/100ps

module host_ctl_top #(
	parameter logic [15:0] BASE_ADDR   = 16'h1000, // start of the 256 byte window
	parameter logic [5:0]  RST_MAX_PKT = 6'h3F,
	parameter int          CNT_WIDTH   = 8         // 1 to 8
) (
	input  logic                   clock,
	input  logic                   rst_addr_cnts_fld,
	// host bus
	input  logic                   req,
	input  host_bus_pkg::host_op_e wr_rd,
	input  logic [15:0]            addr,
	input  logic [7:0]             wdata,
	output logic                   ack,
	output logic [7:0]             rdata,
	// router events
	input  logic                   pkt_done,
	input  logic [1:0]             pkt_dest,
	input  logic                   parity_err,
	input  logic                   len_err,
	// to the router
	output logic [5:0]             max_pkt_len,
	output logic                   router_en,
	output logic                   irq
);

	// ------------------------------
	// internal nets
	// ------------------------------
	logic                     reg_wr;  // one cycle write strobe
	host_regs_pkg::reg_off_e  reg_off;
	logic [7:0]               ctl_rdata;
	logic                     ctl_hit; // offset owned by ctl_regs
	logic [7:0]               en_reg;
	logic                     clr_err_cnts;
	logic                     clr_addr_cnts;
	logic [CNT_WIDTH-1:0]     par_cnt;
	logic [CNT_WIDTH-1:0]     len_cnt;
	logic [CNT_WIDTH-1:0]     ill_cnt;
	logic [CNT_WIDTH-1:0]     addr0_cnt;
	logic [CNT_WIDTH-1:0]     addr1_cnt;
	logic [CNT_WIDTH-1:0]     addr2_cnt;

	host_access_ctl #(
		.BASE_ADDR (BASE_ADDR),
		.CNT_WIDTH (CNT_WIDTH)
	) host_access_ctl_inst (
		.clock             (clock),
		.rst_addr_cnts_fld (rst_addr_cnts_fld),
		.req               (req),
		.wr_rd             (wr_rd),
		.addr              (addr),
		.ctl_rdata         (ctl_rdata),
		.ctl_hit           (ctl_hit),
		.par_cnt           (par_cnt),
		.len_cnt           (len_cnt),
		.ill_cnt           (ill_cnt),
		.addr0_cnt         (addr0_cnt),
		.addr1_cnt         (addr1_cnt),
		.addr2_cnt         (addr2_cnt),
		.ack               (ack),
		.rdata             (rdata),
		.reg_wr            (reg_wr),
		.reg_off           (reg_off)
	);

	ctl_regs #(
		.RST_MAX_PKT (RST_MAX_PKT)
	) ctl_regs_inst (
		.clock             (clock),
		.rst_addr_cnts_fld (rst_addr_cnts_fld),
		.reg_wr            (reg_wr),
		.reg_off           (reg_off),
		.wdata             (wdata),    // straight from the host pins
		.parity_err        (parity_err),
		.len_err           (len_err),
		.pkt_done          (pkt_done),
		.pkt_dest          (pkt_dest),
		.ctl_rdata         (ctl_rdata),
		.ctl_hit           (ctl_hit),
		.en_reg            (en_reg),
		.max_pkt_len       (max_pkt_len),
		.router_en         (router_en),
		.irq               (irq),
		.clr_err_cnts      (clr_err_cnts),
		.clr_addr_cnts     (clr_addr_cnts)
	);

	event_counters #(
		.CNT_WIDTH (CNT_WIDTH)
	) event_counters_inst (
		.clock             (clock),
		.rst_addr_cnts_fld (rst_addr_cnts_fld),
		.en_reg            (en_reg),
		.clr_err_cnts      (clr_err_cnts),
		.clr_addr_cnts     (clr_addr_cnts),
		.parity_err        (parity_err),
		.len_err           (len_err),
		.pkt_done          (pkt_done),
		.pkt_dest          (pkt_dest),
		.par_cnt           (par_cnt),
		.len_cnt           (len_cnt),
		.ill_cnt           (ill_cnt),
		.addr0_cnt         (addr0_cnt),
		.addr1_cnt         (addr1_cnt),
		.addr2_cnt         (addr2_cnt)
	);

endmodule

//--- testbench/host_ctl_model.svh
`ifndef HOST_CTL_MODEL_SVH
`define HOST_CTL_MODEL_SVH

// ------------------------------
// reference register state
// ------------------------------
localparam int C_PAR   = 0; // counter slots
localparam int C_LEN   = 1;
localparam int C_ILL   = 2;
localparam int C_A0    = 3;
localparam int C_A1    = 4;
localparam int C_A2    = 5;
localparam int CNT_MAX = (1 << CNT_WIDTH) - 1; // saturation point

logic [5:0] m_ctrl;
logic [7:0] m_en;
logic [2:0] m_ien;
logic [2:0] m_int;      // sticky status
logic       m_irq;      // status as seen one edge later
int         m_cnt [6];

function automatic void model_reset();
	m_ctrl = RST_MAX_PKT;
	m_en   = host_regs_pkg::RST_EN_REG;
	m_ien  = 3'b000;
	m_int  = 3'b000;
	m_irq  = 1'b0;
	foreach (m_cnt[i]) begin
		m_cnt[i] = 0;
	end
endfunction

function automatic void bump(input int idx, input logic hit);
	if (hit && (m_cnt[idx] < CNT_MAX)) begin
		m_cnt[idx]++; // stops at all ones
	end
endfunction

// one sampled edge worth of router events
function automatic void model_events(input logic par, input logic len, input logic done,
	input logic [1:0] dest);
	logic run;
	logic ill;
	run = m_en[host_regs_pkg::EN_ROUTER_BIT];
	ill = done && (dest == host_regs_pkg::DEST_ILLEGAL);
	bump(C_PAR, run && par && m_en[host_regs_pkg::EN_PAR_BIT]);
	bump(C_LEN, run && len && m_en[host_regs_pkg::EN_LEN_BIT]);
	bump(C_ILL, run && ill && m_en[host_regs_pkg::EN_ILL_BIT]);
	bump(C_A0, run && done && (dest == 2'd0) && m_en[host_regs_pkg::EN_ADDR0_BIT]);
	bump(C_A1, run && done && (dest == 2'd1) && m_en[host_regs_pkg::EN_ADDR1_BIT]);
	bump(C_A2, run && done && (dest == 2'd2) && m_en[host_regs_pkg::EN_ADDR2_BIT]);
	// status ignores the router enable, only its own ien
	m_int[host_regs_pkg::INT_PAR_BIT] |= par && m_ien[host_regs_pkg::INT_PAR_BIT];
	m_int[host_regs_pkg::INT_LEN_BIT] |= len && m_ien[host_regs_pkg::INT_LEN_BIT];
	m_int[host_regs_pkg::INT_ILL_BIT] |= ill && m_ien[host_regs_pkg::INT_ILL_BIT];
endfunction

function automatic void model_write(input logic [15:0] a, input logic [7:0] d);
	int rel;
	rel = int'(a) - int'(BASE_ADDR);
	if ((rel >= 0) && (rel <= 255)) begin
		case (8'(rel))
			host_regs_pkg::CTRL: m_ctrl = d[5:0];
			host_regs_pkg::EN:   m_en   = d & 8'hF7;         // bit 3 reserved
			host_regs_pkg::IEN:  m_ien  = d[2:0];
			host_regs_pkg::INT:  m_int  = m_int & ~d[2:0];   // w1c
			host_regs_pkg::CLR: begin
				if (d[host_regs_pkg::CLR_SOFT_BIT]) begin
					model_reset(); // counters back to zero too
				end
				if (d[host_regs_pkg::CLR_ERR_CNTS_BIT]) begin
					m_cnt[C_PAR] = 0;
					m_cnt[C_LEN] = 0;
					m_cnt[C_ILL] = 0;
				end
				if (d[host_regs_pkg::CLR_ADDR_CNTS_BIT]) begin
					m_cnt[C_A0] = 0;
					m_cnt[C_A1] = 0;
					m_cnt[C_A2] = 0;
				end
				if (d[host_regs_pkg::CLR_INT_BIT]) begin
					m_ien = 3'b000;
					m_int = 3'b000;
				end
			end
			default: ; // read only or unmapped
		endcase
	end
endfunction

function automatic logic [7:0] model_read(input logic [15:0] a);
	int rel;
	logic [7:0] val;
	rel = int'(a) - int'(BASE_ADDR);
	val = 8'h00; // outside the window or unmapped
	if ((rel >= 0) && (rel <= 255)) begin
		case (8'(rel))
			host_regs_pkg::CTRL:      val = {2'b00, m_ctrl};
			host_regs_pkg::EN:        val = m_en;
			host_regs_pkg::IEN:       val = {5'b00000, m_ien};
			host_regs_pkg::INT:       val = {5'b00000, m_int};
			host_regs_pkg::PAR_CNT:   val = 8'(m_cnt[C_PAR]);
			host_regs_pkg::LEN_CNT:   val = 8'(m_cnt[C_LEN]);
			host_regs_pkg::ILL_CNT:   val = 8'(m_cnt[C_ILL]);
			host_regs_pkg::ADDR0_CNT: val = 8'(m_cnt[C_A0]);
			host_regs_pkg::ADDR1_CNT: val = 8'(m_cnt[C_A1]);
			host_regs_pkg::ADDR2_CNT: val = 8'(m_cnt[C_A2]);
			default:                  val = 8'h00; // clr reads back 0 too
		endcase
	end
	return val;
endfunction

`endif

//--- testbench/host_ctl_tb.sv
`timescale 1ns/100ps

module host_ctl_tb;

	localparam logic [15:0] BASE_ADDR   = 16'h1000;
	localparam logic [5:0]  RST_MAX_PKT = 6'h3F;
	localparam int          CNT_WIDTH   = 8;
	localparam int          MAX_HOLD    = 4;   // host keeps req up this long at most
	localparam int          N_RW        = 40;
	localparam int          N_ROUNDS    = 8;
	localparam int          EV_PER_ROUND = 60;
	localparam int          SAT_LEN     = 300; // longer than the counter range
	localparam int          CLR_EV      = 30;
	// bus accesses and event cycles of the whole run
	localparam int N_TRANS  = 13 + N_RW * 5 + N_ROUNDS * 11 + 9 + 14 + 4 * 17;
	localparam int N_EVENTS = N_ROUNDS * EV_PER_ROUND + SAT_LEN + 10 + 4 * (CLR_EV + 1);
	localparam int CYCLE_LIMIT = N_TRANS * 8 + N_EVENTS + 200;

	logic                   clock;
	logic                   rst_addr_cnts_fld;
	logic                   req;
	host_bus_pkg::host_op_e wr_rd;
	logic [15:0]            addr;
	logic [7:0]             wdata;
	logic                   ack;
	logic [7:0]             rdata;
	logic                   pkt_done;
	logic [1:0]             pkt_dest;
	logic                   parity_err;
	logic                   len_err;
	logic [5:0]             max_pkt_len;
	logic                   router_en;
	logic                   irq;
	logic                   par_with_req; // parity pulse on the access edge
	int                     cycle_cnt = 0;

	host_ctl_top #(
		.BASE_ADDR   (BASE_ADDR),
		.RST_MAX_PKT (RST_MAX_PKT),
		.CNT_WIDTH   (CNT_WIDTH)
	) host_ctl_top_inst (.*);

	`include "host_ctl_model.svh"

	always #50 clock = ~clock;

	always @(posedge clock) begin
		cycle_cnt++;
		if (cycle_cnt > CYCLE_LIMIT) begin
			$display("Timeout: test still running after %0d cycles, bus FSM in state %0d",
				cycle_cnt, int'(host_ctl_top_inst.host_access_ctl_inst.state));
			$display("Regression failed");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
			$display("Regression failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	// ------------------------------
	// router event cycles
	// ------------------------------
	task automatic event_cycle(input logic par, input logic len, input logic done,
		input logic [1:0] dest);
		parity_err = par;
		len_err    = len;
		pkt_done   = done;
		pkt_dest   = dest;
		@(posedge clock);
		#10;
		m_irq = |m_int; // irq registers the status from before this edge
		model_events(par, len, done, dest);
		parity_err = 1'b0;
		len_err    = 1'b0;
		pkt_done   = 1'b0;
		check_value("irq", 32'(irq), 32'(m_irq));
		check_value("ack without req", 32'(ack), 32'd0);
	endtask

	task automatic random_event_cycle();
		event_cycle($urandom_range(0, 3) == 0, $urandom_range(0, 3) == 0,
			$urandom_range(0, 1) == 1, 2'($urandom));
	endtask

	// ------------------------------
	// four phase host access
	// ------------------------------
	task automatic bus_access(input host_bus_pkg::host_op_e op, input logic [15:0] a,
		input logic [7:0] d);
		int waits;
		logic [7:0] held;
		logic [7:0] expect_rd;
		repeat ($urandom_range(0, 1)) begin // idle gap
			@(posedge clock);
			#10;
			check_value("ack without req", 32'(ack), 32'd0);
		end
		check_value("ack before req", 32'(ack), 32'd0);
		expect_rd = (op == host_bus_pkg::OP_READ) ? model_read(a) : 8'h00;
		req        = 1'b1;
		wr_rd      = op;
		addr       = a;
		wdata      = d;
		parity_err = par_with_req;
		waits = 0;
		do begin
			@(posedge clock);
			#10;
			waits++;
		end while (!ack);
		parity_err = 1'b0;
		check_value("ack latency", 32'(waits), 32'd1);
		check_value("rdata", 32'(rdata), 32'(expect_rd));
		held = rdata;
		if (op == host_bus_pkg::OP_WRITE) begin
			model_write(a, d);
		end
		if (par_with_req) begin
			model_events(1'b1, 1'b0, 1'b0, 2'd0); // set after the w1c
		end
		repeat ($urandom_range(0, MAX_HOLD)) begin // host holds req
			@(posedge clock);
			#10;
			check_value("ack while req held", 32'(ack), 32'd1);
			check_value("rdata while ack high", 32'(rdata), 32'(held));
		end
		req = 1'b0;
		waits = 0;
		do begin
			@(posedge clock);
			#10;
			waits++;
		end while (ack);
		check_value("ack release latency", 32'(waits), 32'd1);
		check_value("max_pkt_len", 32'(max_pkt_len), 32'(m_ctrl));
		check_value("router_en", 32'(router_en), 32'(m_en[host_regs_pkg::EN_ROUTER_BIT]));
	endtask

	task automatic reg_write(input logic [7:0] off, input logic [7:0] d);
		bus_access(host_bus_pkg::OP_WRITE, BASE_ADDR + 16'(off), d);
	endtask

	task automatic reg_read(input logic [7:0] off);
		bus_access(host_bus_pkg::OP_READ, BASE_ADDR + 16'(off), 8'h00);
	endtask

	initial begin
		int r;
		int b;
		logic [7:0] d;
		logic [7:0] hi;
		clock             = 1'b0;
		rst_addr_cnts_fld = 1'b1;
		req               = 1'b0;
		wr_rd             = host_bus_pkg::OP_READ;
		addr              = 16'h0000;
		wdata             = 8'h00;
		pkt_done          = 1'b0;
		pkt_dest          = 2'd0;
		parity_err        = 1'b0;
		len_err           = 1'b0;
		par_with_req      = 1'b0;
		void'($urandom(32'ha01f_b403));
		model_reset();
		repeat (3) @(posedge clock);
		#10;
		rst_addr_cnts_fld = 1'b0;

		// reset values
		check_value("ack after reset", 32'(ack), 32'd0);
		check_value("irq after reset", 32'(irq), 32'd0);
		check_value("router_en after reset", 32'(router_en), 32'd1);
		check_value("max_pkt_len after reset", 32'(max_pkt_len), 32'h3F);
		for (b = 0; b <= 12; b++) begin
			reg_read(8'(b));
		end

		// random register traffic in and out of the window
		repeat (N_RW) begin
			d = 8'($urandom_range(0, 3)); // ctrl, en, ien or int
			reg_write(d, 8'($urandom));
			reg_read(d);
			hi = 8'($urandom_range(0, 254));
			if (hi >= BASE_ADDR[15:8]) begin
				hi++; // skip the window page
			end
			bus_access(host_bus_pkg::OP_WRITE, {hi, 8'($urandom)}, 8'($urandom));
			bus_access(host_bus_pkg::OP_READ, {hi, 8'($urandom)}, 8'h00);
			reg_read(8'($urandom)); // any offset
		end

		// ------------------------------
		// counters under random enables
		// ------------------------------
		for (r = 0; r < N_ROUNDS; r++) begin
			d = 8'($urandom);
			d[host_regs_pkg::EN_ROUTER_BIT] = (r % 4 != 3); // router off now and then
			reg_write(host_regs_pkg::EN, d);
			reg_write(host_regs_pkg::IEN, 8'($urandom));
			repeat (EV_PER_ROUND) random_event_cycle();
			for (b = 4; b <= 11; b++) begin
				reg_read(8'(b));
			end
			reg_write(host_regs_pkg::INT, 8'($urandom));
		end
		reg_write(host_regs_pkg::EN, 8'hF7);
		repeat (SAT_LEN) event_cycle(1'b1, 1'b0, 1'b1, 2'd1); // drive two counters to max
		for (b = 4; b <= 11; b++) begin
			reg_read(8'(b));
		end

		// interrupt status and irq
		reg_write(host_regs_pkg::CLR, 8'h08);
		event_cycle(1'b1, 1'b1, 1'b1, host_regs_pkg::DEST_ILLEGAL); // all ien off
		reg_read(host_regs_pkg::INT);
		reg_write(host_regs_pkg::IEN, 8'h01);
		event_cycle(1'b0, 1'b1, 1'b0, 2'd0);
		event_cycle(1'b1, 1'b0, 1'b0, 2'd0);
		event_cycle(1'b0, 1'b0, 1'b0, 2'd0);
		reg_read(host_regs_pkg::INT);
		reg_write(host_regs_pkg::INT, 8'h00); // 0 keeps it
		reg_read(host_regs_pkg::INT);
		reg_write(host_regs_pkg::INT, 8'h01);
		reg_read(host_regs_pkg::INT);
		event_cycle(1'b1, 1'b0, 1'b0, 2'd0);
		event_cycle(1'b0, 1'b0, 1'b0, 2'd0);
		par_with_req = 1'b1; // set and w1c on the same edge
		reg_write(host_regs_pkg::INT, 8'h01);
		par_with_req = 1'b0;
		reg_read(host_regs_pkg::INT);
		reg_write(host_regs_pkg::IEN, 8'h07);
		event_cycle(1'b0, 1'b1, 1'b1, host_regs_pkg::DEST_ILLEGAL);
		event_cycle(1'b0, 1'b0, 1'b0, 2'd0);
		reg_read(host_regs_pkg::INT);
		reg_write(host_regs_pkg::INT, 8'h07);
		event_cycle(1'b0, 1'b0, 1'b0, 2'd0);
		event_cycle(1'b0, 1'b0, 1'b0, 2'd0);
		reg_read(host_regs_pkg::INT);

		// each clear bit on its own
		for (b = 0; b < 4; b++) begin
			reg_write(host_regs_pkg::EN, 8'hF7);
			reg_write(host_regs_pkg::IEN, 8'h07);
			reg_write(host_regs_pkg::CTRL, 8'($urandom));
			repeat (CLR_EV) random_event_cycle();
			reg_write(host_regs_pkg::CLR, 8'(1 << b));
			event_cycle(1'b0, 1'b0, 1'b0, 2'd0);
			for (r = 0; r <= 12; r++) begin
				reg_read(8'(r));
			end
		end

		$display("Regression passed");
		$finish;
	end

endmodule

//--- sources.f
+incdir+testbench
common/host_regs_pkg.sv
common/host_bus_pkg.sv
design/host_access_ctl.sv
ctl_regs/ctl_regs.sv
design/event_counters.sv
design/host_ctl_top.sv
testbench/host_ctl_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the host register block testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module host_ctl_tb \
	-f sources.f -o host_ctl_sim \
	&& ./obj_dir/host_ctl_sim > sim.log 2>&1 \
	|| echo "build or simulation ended with an error"

# the log decides
grep -qx "Regression passed" sim.log \
	&& echo "simulation ok" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
